// File: files.f
verilog/exe_pkg.sv
verilog/exe_alu.sv
verilog/exe_branch.sv
verilog/exe_unit.sv
verilog/exe_stage.sv
verilog/ex_top.sv
test/ex_checker.sv
test/tb_ex_top.sv

// File: test/ex_checker.sv
/* Watches both handshakes of ex_top and checks each result against a model of the
   execute rules. Samples on the rising edge, before that edge's updates land. */
module ex_checker import exe_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     i_dec_req,
  input logic     i_dec_ack,
  input dec_pkt_t i_dec_pkt,
  input logic     i_exec_req,
  input logic     i_exec_ack,
  input exe_pkt_t i_exec_pkt
);
  timeunit 1ns;
  timeprecision 100ps;

  // 0 reset, 1 alu, 2 branch, 3 memory, 4 ordering, 5 latency
  string    names [6] = '{"reset", "alu and upper imm", "branch and jump",
                          "load and store", "ordering and hold", "latency"};
  int       checks [6] = '{default: 0};
  int       errs [6] = '{default: 0};
  dec_pkt_t pending [$];
  logic     saw_rst = 1'b0;
  logic     expect_req = 1'b0;
  logic     hold_prev = 1'b0;
  exe_pkt_t held_pkt;

  function automatic logic is_writer(rv_opcode_e opc);
    return opc inside {op_imm, op, op_imm_32, op_32, lui, auipc, jal, jalr};
  endfunction

  function automatic int category(rv_opcode_e opc);
    if (opc inside {branch, jal, jalr}) return 2;
    if (opc inside {load, store}) return 3;
    return 1;
  endfunction

  function automatic xlen_t model_alu(dec_pkt_t d);
    logic        word;
    logic        neg;
    int unsigned sh;
    xlen_t       a;
    xlen_t       b;
    xlen_t       r;
    logic [31:0] w;
    word = (d.opcode == op_imm_32) || (d.opcode == op_32);
    neg  = d.funct7[5];
    a    = d.op1;
    b    = d.op2;
    sh   = word ? b[4:0] : b[5:0];
    case (d.funct3)
      3'd0: r = (neg && (d.opcode == op || d.opcode == op_32)) ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'd3: r = (a < b) ? 64'd1 : 64'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        w = a[31:0];
        // word shifts work on a widened copy of the low half
        if (word) begin
          r = neg ? ({{32{w[31]}}, w} >> sh) : ({32'd0, w} >> sh);
        end else if (neg) begin
          r = $signed(a) >>> sh;
        end else begin
          r = a >> sh;
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    if (word) begin
      r = {{32{r[31]}}, r[31:0]};
    end
    return r;
  endfunction

  function automatic xlen_t model_next_pc(dec_pkt_t d);
    logic  cond;
    xlen_t s;
    case (d.funct3)
      3'd0: cond = (d.op1 == d.op2);
      3'd1: cond = (d.op1 != d.op2);
      3'd4: cond = $signed(d.op1) < $signed(d.op2);
      3'd5: cond = !($signed(d.op1) < $signed(d.op2));
      3'd6: cond = d.op1 < d.op2;
      3'd7: cond = !(d.op1 < d.op2);
      default: cond = 1'b0;
    endcase
    s = d.op1 + d.op2;
    s[0] = 1'b0;
    if (d.opcode == jal || (d.opcode == branch && cond)) return d.pc + d.t1;
    if (d.opcode == jalr) return s;
    return d.pc + 64'd4;
  endfunction

  function automatic exe_pkt_t model_exec(dec_pkt_t d);
    exe_pkt_t e;
    e            = '0;
    e.pc         = d.pc;
    e.inst       = d.inst;
    e.funct3     = d.funct3;
    e.pc_jmpaddr = model_next_pc(d);
    e.pc_jmp     = (e.pc_jmpaddr != d.pc_pred);
    e.rd         = d.rd;
    case (d.opcode)
      lui:       e.rd_wdata = d.op2;
      auipc:     e.rd_wdata = d.pc + d.op2;
      jal, jalr: e.rd_wdata = d.pc + 64'd4;
      store:     e.rd_wdata = d.t1;
      default:   e.rd_wdata = is_writer(d.opcode) ? model_alu(d) : '0;
    endcase
    e.rd_wen    = is_writer(d.opcode) && (d.rd != '0);
    e.memaddr   = d.memaddr;
    e.memren    = d.memren && (d.opcode == load);
    e.memwen    = d.memwen && (d.opcode == store);
    e.nocmt     = d.nocmt;
    e.skipcmt   = d.skipcmt;
    e.memaction = d.memaction;
    return e;
  endfunction

  task automatic compare_field(int t, string field, xlen_t got, xlen_t exp);
    checks[t]++;
    if (got !== exp) begin
      errs[t]++;
      $display("Fail %0t: %s got %h expected %h", $time, field, got, exp);
    end
  endtask

  task automatic compare_result(dec_pkt_t d, exe_pkt_t got);
    exe_pkt_t exp;
    int       t;
    exp = model_exec(d);
    t   = category(d.opcode);
    // pc and inst identify the item, so they carry the ordering check
    compare_field(4, "pc", got.pc, exp.pc);
    compare_field(4, "inst", got.inst, exp.inst);
    compare_field(t, "funct3", got.funct3, exp.funct3);
    compare_field(t, "rd", got.rd, exp.rd);
    compare_field(t, "rd_wen", got.rd_wen, exp.rd_wen);
    if (is_writer(d.opcode) || d.opcode == store) begin
      compare_field(t, "rd_wdata", got.rd_wdata, exp.rd_wdata);
    end
    compare_field(t, "pc_jmpaddr", got.pc_jmpaddr, exp.pc_jmpaddr);
    compare_field(t, "pc_jmp", got.pc_jmp, exp.pc_jmp);
    compare_field(t, "memaddr", got.memaddr, exp.memaddr);
    compare_field(t, "memren", got.memren, exp.memren);
    compare_field(t, "memwen", got.memwen, exp.memwen);
    compare_field(t, "nocmt", got.nocmt, exp.nocmt);
    compare_field(t, "skipcmt", got.skipcmt, exp.skipcmt);
    compare_field(t, "memaction", got.memaction, exp.memaction);
  endtask

  always @(posedge clk) begin : watch
    dec_pkt_t d;
    if (rst) begin
      saw_rst    = 1'b1;
      expect_req = 1'b0;
      hold_prev  = 1'b0;
      pending.delete();
    end else begin
      if (saw_rst) begin
        saw_rst = 1'b0;
        compare_field(0, "o_exec_req after reset", i_exec_req, 1'b0);
        compare_field(0, "o_dec_ack after reset", i_dec_ack, 1'b1);
      end
      if (expect_req) begin
        compare_field(5, "o_exec_req after accept", i_exec_req, 1'b1);
      end
      if (hold_prev) begin
        compare_field(4, "o_exec_req under back-pressure", i_exec_req, 1'b1);
        checks[4]++;
        if (i_exec_pkt !== held_pkt) begin
          errs[4]++;
          $display("Fail %0t: o_exec_pkt changed under back-pressure", $time);
        end
      end
      // pop before push, a new item may enter as the held one leaves
      if (i_exec_req && i_exec_ack) begin
        if (pending.size() == 0) begin
          checks[4]++;
          errs[4]++;
          $display("a result was offered at %0t with no accepted item pending", $time);
        end else begin
          d = pending.pop_front();
          compare_result(d, i_exec_pkt);
        end
      end
      expect_req = i_dec_req && i_dec_ack && !i_exec_req;
      hold_prev  = i_exec_req && !i_exec_ack;
      held_pkt   = i_exec_pkt;
      if (i_dec_req && i_dec_ack) begin
        pending.push_back(i_dec_pkt);
      end
    end
  end

  task automatic print_summary(output int total_errs);
    int tc;
    int te;
    tc = 0;
    te = 0;
    checks[4]++;
    if (pending.size() != 0) begin
      errs[4]++;
      $display("%0d accepted items never produced a result", pending.size());
    end
    for (int i = 0; i < 6; i++) begin
      if (checks[i] == 0) begin
        errs[i]++;
        $display("test %s never ran a check", names[i]);
      end
      $display("test %-18s %6d checks %4d errors  %s", names[i], checks[i], errs[i],
               (errs[i] == 0) ? "ok" : "failed");
      tc += checks[i];
      te += errs[i];
    end
    $display("total: %0d checks, %0d errors", tc, te);
    total_errs = te;
  endtask

endmodule

// File: test/tb_ex_top.sv
/* Random stimulus for ex_top, seed 80983, fixed item count. Downstream acknowledges
   about 60 percent of cycles; every handshake wait gives up after a cycle limit. */
module tb_ex_top import exe_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_items    = 600;
  localparam int wait_limit = 200;

  logic     clk;
  logic     rst;
  logic     dec_req;
  logic     dec_ack;
  dec_pkt_t dec_pkt;
  logic     exec_req;
  logic     exec_ack;
  exe_pkt_t exec_pkt;

  ex_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .i_dec_req  (dec_req),
    .o_dec_ack  (dec_ack),
    .i_dec_pkt  (dec_pkt),
    .o_exec_req (exec_req),
    .i_exec_ack (exec_ack),
    .o_exec_pkt (exec_pkt)
  );

  ex_checker i_chk (
    .clk        (clk),
    .rst        (rst),
    .i_dec_req  (dec_req),
    .i_dec_ack  (dec_ack),
    .i_dec_pkt  (dec_pkt),
    .i_exec_req (exec_req),
    .i_exec_ack (exec_ack),
    .i_exec_pkt (exec_pkt)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    exec_ack <= ($urandom_range(0, 99) < 60);
  end

  // edge values show up often
  function automatic xlen_t random_word();
    case ($urandom_range(0, 7))
      0: return '0;
      1: return '1;
      2: return 64'h8000_0000_0000_0000;
      3: return 64'h0000_0000_8000_0000;
      default: return {$urandom(), $urandom()};
    endcase
  endfunction

  function automatic xlen_t signed_imm12();
    logic [11:0] v;
    v = 12'($urandom());
    return {{52{v[11]}}, v};
  endfunction

  function automatic dec_pkt_t make_item();
    dec_pkt_t    p;
    int          sel;
    logic [12:0] off;
    logic [19:0] up;
    p   = '0;
    sel = $urandom_range(0, 99);
    if (sel < 20)      p.opcode = op_imm;
    else if (sel < 35) p.opcode = op;
    else if (sel < 45) p.opcode = op_imm_32;
    else if (sel < 55) p.opcode = op_32;
    else if (sel < 60) p.opcode = lui;
    else if (sel < 65) p.opcode = auipc;
    else if (sel < 80) p.opcode = branch;
    else if (sel < 85) p.opcode = jal;
    else if (sel < 90) p.opcode = jalr;
    else if (sel < 95) p.opcode = load;
    else               p.opcode = store;
    p.pc        = {$urandom(), $urandom()} & ~64'd3;
    p.inst      = $urandom();
    p.inst[6:0] = p.opcode;
    p.funct3    = 3'($urandom_range(0, 7));
    p.op1       = random_word();
    p.op2       = random_word();
    off         = 13'($urandom());
    off[0]      = 1'b0;
    p.t1        = {{51{off[12]}}, off};
    up          = 20'($urandom());
    case (p.opcode)
      op_imm_32, op_32: p.funct3 = 3'(($urandom_range(0, 2) == 2) ? 5 : $urandom_range(0, 1));
      branch: begin
        // 010 and 011 are not legal conditions
        p.funct3 = 3'($urandom_range(0, 5));
        if (p.funct3 >= 3'd2) p.funct3 = p.funct3 + 3'd2;
      end
      lui, auipc: p.op2 = {{32{up[19]}}, up, 12'h000};
      jalr: p.op2 = signed_imm12();
      store: p.t1 = random_word();
      default: ;
    endcase
    if (p.opcode inside {op_imm, op, op_imm_32, op_32}) begin
      if (p.funct3 == 3'd5 || (p.funct3 == 3'd0 && p.opcode inside {op, op_32})) begin
        p.funct7 = $urandom_range(0, 1) ? 7'h20 : 7'h00;
      end
    end
    if (p.opcode == op_imm || p.opcode == op_imm_32) begin
      if (p.funct3 == 3'd1 || p.funct3 == 3'd5) begin
        p.op2 = (p.opcode == op_imm) ? $urandom_range(0, 63) : $urandom_range(0, 31);
      end else begin
        p.op2    = signed_imm12();
        // funct7 field holds the upper immediate bits
        p.funct7 = p.op2[11:5];
      end
    end
    p.memaddr   = random_word();
    p.memren    = (p.opcode == load);
    p.memwen    = (p.opcode == store);
    p.rd        = ($urandom_range(0, 9) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
    p.nocmt     = 1'($urandom());
    p.skipcmt   = 1'($urandom());
    p.memaction = 2'($urandom());
    // simple guess that is right about half the time
    if ($urandom_range(0, 1) == 1) begin
      case (p.opcode)
        jal:     p.pc_pred = p.pc + p.t1;
        jalr:    p.pc_pred = (p.op1 + p.op2) & ~64'd1;
        branch:  p.pc_pred = $urandom_range(0, 1) ? p.pc + p.t1 : p.pc + 64'd4;
        default: p.pc_pred = p.pc + 64'd4;
      endcase
    end else begin
      p.pc_pred = {$urandom(), $urandom()} & ~64'd1;
    end
    return p;
  endfunction

  task automatic send_item(input dec_pkt_t pkt, output bit stalled);
    int waited;
    dec_req <= 1'b1;
    dec_pkt <= pkt;
    waited  = 0;
    stalled = 1'b0;
    do begin
      @(posedge clk);
      waited++;
      stalled = !dec_ack && (waited >= wait_limit);
    end while (!dec_ack && !stalled);
  endtask

  initial begin
    int    errors;
    int    waited;
    bit    stalled;
    string stall_on;
    void'($urandom(80983));
    rst      = 1'b1;
    dec_req  = 1'b0;
    dec_pkt  = '0;
    exec_ack = 1'b0;
    stalled  = 1'b0;
    stall_on = "the decoded handshake";
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < n_items && !stalled; n++) begin
      if ($urandom_range(0, 3) == 0) begin
        dec_req <= 1'b0;
        repeat ($urandom_range(1, 3)) @(posedge clk);
      end
      send_item(make_item(), stalled);
    end
    dec_req <= 1'b0;
    if (!stalled) begin
      stall_on = "draining the last result";
      waited   = 0;
      do begin
        @(posedge clk);
        waited++;
        stalled = exec_req && (waited >= wait_limit);
      end while (exec_req && !stalled);
    end
    if (stalled) begin
      $display("timeout: no progress on %s after %0d cycles", stall_on, wait_limit);
      $display("RESULT: FAIL");
    end else begin
      repeat (2) @(posedge clk);
      i_chk.print_summary(errors);
      if (errors == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
    end
    $finish;
  end

endmodule

// File: verilog/ex_top.sv
/* Execute stage top. Both sides use level req with ack; transfer when both high. */
module ex_top import exe_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_dec_req,
  output logic     o_dec_ack,
  input  dec_pkt_t i_dec_pkt,
  output logic     o_exec_req,
  input  logic     i_exec_ack,
  output exe_pkt_t o_exec_pkt
);

  exe_stage u_stage (
    .clk        (clk),
    .rst        (rst),
    .i_dec_req  (i_dec_req),
    .o_dec_ack  (o_dec_ack),
    .i_dec_pkt  (i_dec_pkt),
    .o_exec_req (o_exec_req),
    .i_exec_ack (i_exec_ack),
    .o_exec_pkt (o_exec_pkt)
  );

endmodule

// File: verilog/exe_alu.sv
/* RV64I integer ALU, combinational. W forms use the low 32 bits and sign-extend.
   funct7[5] picks sub only for register forms, and sra for shifts in both forms. */
module exe_alu import exe_pkg::*; (
  input  rv_opcode_e i_opcode,
  input  funct3_t    i_funct3,
  input  funct7_t    i_funct7,
  input  xlen_t      i_op1,
  input  xlen_t      i_op2,
  output xlen_t      o_result
);

  logic        is_word;
  logic        is_reg;
  logic        alt;
  logic [5:0]  shamt;
  logic [31:0] lo_a;
  logic [31:0] lo_b;
  xlen_t       res64;
  logic [31:0] res32;

  assign is_word = (i_opcode == op_imm_32) || (i_opcode == op_32);
  assign is_reg  = (i_opcode == op) || (i_opcode == op_32);
  assign alt     = i_funct7[5];
  assign shamt   = i_op2[5:0];
  assign lo_a    = i_op1[31:0];
  assign lo_b    = i_op2[31:0];

  // full width
  always_comb begin
    res64 = '0;
    case (i_funct3)
      f3_add: begin
        if (is_reg && alt) begin
          res64 = i_op1 - i_op2;
        end else begin
          res64 = i_op1 + i_op2;
        end
      end
      f3_sll:  res64 = i_op1 << shamt;
      f3_slt:  res64 = xlen_t'($signed(i_op1) < $signed(i_op2));
      f3_sltu: res64 = xlen_t'(i_op1 < i_op2);
      f3_xor:  res64 = i_op1 ^ i_op2;
      f3_sr: begin
        // kept apart so >>> stays signed
        if (alt) begin
          res64 = $signed(i_op1) >>> shamt;
        end else begin
          res64 = i_op1 >> shamt;
        end
      end
      f3_or:   res64 = i_op1 | i_op2;
      f3_and:  res64 = i_op1 & i_op2;
      default: res64 = '0;
    endcase
  end

  // word forms, 5-bit shift amount
  always_comb begin
    res32 = res64[31:0];
    case (i_funct3)
      f3_add: begin
        if (is_reg && alt) begin
          res32 = lo_a - lo_b;
        end else begin
          res32 = lo_a + lo_b;
        end
      end
      f3_sll: res32 = lo_a << shamt[4:0];
      f3_sr: begin
        if (alt) begin
          res32 = $signed(lo_a) >>> shamt[4:0];
        end else begin
          res32 = lo_a >> shamt[4:0];
        end
      end
      default: res32 = res64[31:0];
    endcase
  end

  assign o_result = is_word ? {{32{res32[31]}}, res32} : res64;

endmodule

// File: verilog/exe_branch.sv
/* Next-pc resolution. o_pc_jmpaddr is always the true next pc, and o_pc_jmp flags a
   mismatch with the decoder's prediction, so sequential flow is checked as well. */
module exe_branch import exe_pkg::*; (
  input  rv_opcode_e i_opcode,
  input  funct3_t    i_funct3,
  input  xlen_t      i_pc,
  input  xlen_t      i_op1,
  input  xlen_t      i_op2,
  input  xlen_t      i_t1,
  input  xlen_t      i_pc_pred,
  output logic       o_pc_jmp,
  output xlen_t      o_pc_jmpaddr
);

  logic  taken;
  xlen_t pc_seq;
  xlen_t pc_tgt;
  xlen_t jalr_tgt;
  xlen_t next_pc;

  assign pc_seq   = i_pc + 64'd4;
  assign pc_tgt   = i_pc + i_t1;
  assign jalr_tgt = (i_op1 + i_op2) & ~64'd1;

  // condition, 010 and 011 are not branches
  always_comb begin
    case (i_funct3)
      f3_beq:  taken = (i_op1 == i_op2);
      f3_bne:  taken = (i_op1 != i_op2);
      f3_blt:  taken = ($signed(i_op1) < $signed(i_op2));
      f3_bge:  taken = ($signed(i_op1) >= $signed(i_op2));
      f3_bltu: taken = (i_op1 < i_op2);
      f3_bgeu: taken = (i_op1 >= i_op2);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (i_opcode)
      branch:  next_pc = taken ? pc_tgt : pc_seq;
      jal:     next_pc = pc_tgt;
      jalr:    next_pc = jalr_tgt;
      default: next_pc = pc_seq;
    endcase
  end

  assign o_pc_jmpaddr = next_pc;
  assign o_pc_jmp     = (next_pc != i_pc_pred);

endmodule

// File: verilog/exe_pkg.sv
/* RV64I execute stage types. Opcodes outside rv_opcode_e execute as no-ops.
   memaction is opaque here and only forwarded to the memory stage. */
package exe_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  ridx_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [1:0]  memact_t;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_imm    = 7'b0010011,
    op        = 7'b0110011,
    op_imm_32 = 7'b0011011,
    op_32     = 7'b0111011,
    lui       = 7'b0110111,
    auipc     = 7'b0010111,
    jal       = 7'b1101111,
    jalr      = 7'b1100111,
    branch    = 7'b1100011,
    load      = 7'b0000011,
    store     = 7'b0100011
  } rv_opcode_e;

  // alu funct3
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // branch funct3
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // decoded instruction from the decode stage
  typedef struct packed {
    xlen_t      pc;
    inst_t      inst;
    rv_opcode_e opcode;
    funct3_t    funct3;
    funct7_t    funct7;
    xlen_t      op1;
    xlen_t      op2;
    // branch/jal offset, or store data
    xlen_t      t1;
    xlen_t      memaddr;
    logic       memren;
    logic       memwen;
    xlen_t      pc_pred;
    ridx_t      rd;
    logic       nocmt;
    logic       skipcmt;
    memact_t    memaction;
  } dec_pkt_t;

  // executed result toward the memory stage
  typedef struct packed {
    xlen_t   pc;
    inst_t   inst;
    funct3_t funct3;
    logic    pc_jmp;
    xlen_t   pc_jmpaddr;
    ridx_t   rd;
    logic    rd_wen;
    xlen_t   rd_wdata;
    xlen_t   memaddr;
    logic    memren;
    logic    memwen;
    logic    nocmt;
    logic    skipcmt;
    memact_t memaction;
  } exe_pkt_t;

endpackage

// File: verilog/exe_stage.sv
/* One-slot execute stage. A new item may enter in the cycle the held one leaves.
   o_exec_pkt is meaningful only while o_exec_req is high. */
module exe_stage import exe_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_dec_req,
  output logic     o_dec_ack,
  input  dec_pkt_t i_dec_pkt,
  output logic     o_exec_req,
  input  logic     i_exec_ack,
  output exe_pkt_t o_exec_pkt
);

  dec_pkt_t held;
  logic     full;
  logic     dec_hs;
  logic     exec_hs;

  assign exec_hs    = full && i_exec_ack;
  assign o_dec_ack  = !full || i_exec_ack;
  assign dec_hs     = i_dec_req && o_dec_ack;
  assign o_exec_req = full;

  // occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (dec_hs) begin
      full <= 1'b1;
    end else if (exec_hs) begin
      full <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (dec_hs) begin
      held <= i_dec_pkt;
    end
  end

  exe_unit u_unit (
    .i_valid (full),
    .i_pkt   (held),
    .o_pkt   (o_exec_pkt)
  );

  // back-pressure holds the offered result
  a_exec_stable: assert property (
    @(posedge clk) disable iff (rst)
    (o_exec_req && !i_exec_ack) |=> (o_exec_req && $stable(o_exec_pkt))
  ) else $error("exe_stage: o_exec_pkt changed under back-pressure");

  // slot comes out of reset empty
  a_reset_empty: assert property (
    @(posedge clk) $fell(rst) |-> !o_exec_req
  ) else $error("exe_stage: o_exec_req high after reset");

endmodule

// File: verilog/exe_unit.sv
/* Combinational execute from the held packet. Loads never write rd here;
   the memory stage does. Writes to x0 are suppressed. */
module exe_unit import exe_pkg::*; (
  input  logic     i_valid,
  input  dec_pkt_t i_pkt,
  output exe_pkt_t o_pkt
);

  xlen_t alu_res;
  logic  pc_jmp;
  xlen_t pc_jmpaddr;
  xlen_t wdata;
  logic  wen;

  exe_alu u_alu (
    .i_opcode (i_pkt.opcode),
    .i_funct3 (i_pkt.funct3),
    .i_funct7 (i_pkt.funct7),
    .i_op1    (i_pkt.op1),
    .i_op2    (i_pkt.op2),
    .o_result (alu_res)
  );

  exe_branch u_branch (
    .i_opcode     (i_pkt.opcode),
    .i_funct3     (i_pkt.funct3),
    .i_pc         (i_pkt.pc),
    .i_op1        (i_pkt.op1),
    .i_op2        (i_pkt.op2),
    .i_t1         (i_pkt.t1),
    .i_pc_pred    (i_pkt.pc_pred),
    .o_pc_jmp     (pc_jmp),
    .o_pc_jmpaddr (pc_jmpaddr)
  );

  // writeback select
  always_comb begin
    wdata = '0;
    wen   = 1'b0;
    case (i_pkt.opcode)
      op_imm, op, op_imm_32, op_32: begin
        wdata = alu_res;
        wen   = 1'b1;
      end
      lui: begin
        wdata = i_pkt.op2;
        wen   = 1'b1;
      end
      auipc: begin
        wdata = i_pkt.pc + i_pkt.op2;
        wen   = 1'b1;
      end
      jal, jalr: begin
        wdata = i_pkt.pc + 64'd4;
        wen   = 1'b1;
      end
      // store data rides in rd_wdata
      store:   wdata = i_pkt.t1;
      default: wen = 1'b0;
    endcase
  end

  always_comb begin
    o_pkt            = '0;
    o_pkt.pc         = i_pkt.pc;
    o_pkt.inst       = i_pkt.inst;
    o_pkt.funct3     = i_pkt.funct3;
    o_pkt.pc_jmp     = pc_jmp;
    o_pkt.pc_jmpaddr = pc_jmpaddr;
    o_pkt.rd         = i_pkt.rd;
    o_pkt.rd_wen     = wen && (i_pkt.rd != 5'd0);
    o_pkt.rd_wdata   = wdata;
    o_pkt.memaddr    = i_pkt.memaddr;
    o_pkt.memren     = i_pkt.memren && (i_pkt.opcode == load);
    o_pkt.memwen     = i_pkt.memwen && (i_pkt.opcode == store);
    o_pkt.nocmt      = i_pkt.nocmt;
    o_pkt.skipcmt    = i_pkt.skipcmt;
    o_pkt.memaction  = i_pkt.memaction;
  end

  // a held item never asks for both read and write
  always_comb begin
    assert final (!(i_valid && i_pkt.memren && i_pkt.memwen))
      else $error("exe_unit: memren and memwen both high");
  end

endmodule
